// File: common/ft245_pkg.sv
`default_nettype none

package ft245_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus word and beat
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // one 16-bit word of the 245 bus
    typedef logic [15:0] ft_data_t;

    // byte enables, a set bit marks a valid byte
    typedef logic [1:0] ft_be_t;

    // captured, stored and streamed as one unit
    typedef struct packed {
        ft_data_t data;
        ft_be_t   keep;
    } ft_beat_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // fmc adjustable voltage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [1:0] vadj_code_t;

    // 2.5 V select
    localparam vadj_code_t VADJ_2V5 = 2'b10;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read engine
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [2:0] {
        RX_WAIT_POWER,
        RX_IDLE,
        RX_OE,
        RX_READ,
        RX_RELEASE
    } rx_state_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // receive fifo
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int FIFO_DEPTH  = 16;
    localparam int FIFO_ADDR_W = 4;

    // free slots left when almost-full rises, covers words still in flight
    localparam int FIFO_MARGIN = 4;

    typedef logic [FIFO_ADDR_W-1:0] fifo_addr_t;

    // one bit wider than the address so a full fifo can be counted
    typedef logic [FIFO_ADDR_W:0] fifo_count_t;

endpackage

`default_nettype wire

// File: ft245/ft245_rx_engine.sv
`default_nettype none

module ft245_rx_engine (
    input  wire logic                fmc_clk,
    input  wire logic                reset,
    input  wire logic                power_good,
    input  wire logic                fmc_rxfn,
    input  wire ft245_pkg::ft_data_t fmc_data,
    input  wire ft245_pkg::ft_be_t   fmc_be,
    output logic                     fmc_oen,
    output logic                     fmc_rdn,
    input  wire logic                almost_full,
    output logic                     capture_valid,
    output ft245_pkg::ft_beat_t      capture_beat
);

    ft245_pkg::rx_state_t state;

    logic word_accepted;
    logic can_open;
    logic stop_burst;

    // chip hands over a word on every edge with rd# and rxf# both low
    assign word_accepted = !fmc_rdn && !fmc_rxfn;

    // data waiting and room left in the fifo
    assign can_open = power_good && !fmc_rxfn && !almost_full;

    assign stop_burst = fmc_rxfn || almost_full;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // strobe sequencing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // oe# leads rd# by one cycle on the way in and trails it on the way out
    always_ff @(posedge fmc_clk)
    begin
        if (reset)
        begin
            state   <= ft245_pkg::RX_WAIT_POWER;
            fmc_oen <= 1'b1;
            fmc_rdn <= 1'b1;
        end
        else
        begin
            case (state)
                ft245_pkg::RX_WAIT_POWER:
                begin
                    if (power_good)
                        state <= ft245_pkg::RX_IDLE;
                end
                ft245_pkg::RX_IDLE:
                begin
                    if (can_open)
                    begin
                        fmc_oen <= 1'b0;
                        state   <= ft245_pkg::RX_OE;
                    end
                end
                ft245_pkg::RX_OE:
                begin
                    // rd# never went low, so oe# may close right away
                    if (stop_burst)
                    begin
                        fmc_oen <= 1'b1;
                        state   <= ft245_pkg::RX_IDLE;
                    end
                    else
                    begin
                        fmc_rdn <= 1'b0;
                        state   <= ft245_pkg::RX_READ;
                    end
                end
                ft245_pkg::RX_READ:
                begin
                    if (stop_burst)
                    begin
                        fmc_rdn <= 1'b1;
                        state   <= ft245_pkg::RX_RELEASE;
                    end
                end
                ft245_pkg::RX_RELEASE:
                begin
                    fmc_oen <= 1'b1;
                    state   <= ft245_pkg::RX_IDLE;
                end
                default:
                begin
                    fmc_oen <= 1'b1;
                    fmc_rdn <= 1'b1;
                    state   <= ft245_pkg::RX_IDLE;
                end
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // word capture
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // one push per accepted word, a cycle after the accepting edge
    always_ff @(posedge fmc_clk)
    begin
        if (reset)
            capture_valid <= 1'b0;
        else
            capture_valid <= word_accepted;
    end

    always_ff @(posedge fmc_clk)
    begin
        if (word_accepted)
        begin
            capture_beat.data <= fmc_data;
            capture_beat.keep <= fmc_be;
        end
    end

endmodule

`default_nettype wire

// File: ft245/rx_word_fifo.sv
`default_nettype none

module rx_word_fifo (
    input  wire logic                fmc_clk,
    input  wire logic                reset,
    input  wire logic                push_valid,
    input  wire ft245_pkg::ft_beat_t push_beat,
    output logic                     almost_full,
    output logic                     out_valid,
    output ft245_pkg::ft_beat_t      out_beat,
    input  wire logic                out_ready
);

    ft245_pkg::ft_beat_t mem [ft245_pkg::FIFO_DEPTH];

    ft245_pkg::fifo_addr_t  wr_ptr;
    ft245_pkg::fifo_addr_t  rd_ptr;
    ft245_pkg::fifo_count_t count;
    ft245_pkg::fifo_count_t free_slots;

    logic full;
    logic do_push;
    logic do_pop;

    assign full       = (count == ft245_pkg::fifo_count_t'(ft245_pkg::FIFO_DEPTH));
    assign free_slots = ft245_pkg::fifo_count_t'(ft245_pkg::FIFO_DEPTH) - count;

    // engine stops its burst here, the margin absorbs words already in flight
    assign almost_full = (free_slots <= ft245_pkg::fifo_count_t'(ft245_pkg::FIFO_MARGIN));

    assign do_push = push_valid && !full;
    assign do_pop  = out_valid && out_ready;

    // head entry, held until popped since writes never reach it
    assign out_valid = (count != '0);
    assign out_beat  = mem[rd_ptr];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // storage and pointers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge fmc_clk)
    begin
        if (do_push)
            mem[wr_ptr] <= push_beat;
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge fmc_clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f vlog.f --top-module fmc_ft245_rx_bridge_tb -o fmc_ft245_rx_bridge_sim

output=$(./obj_dir/fmc_ft245_rx_bridge_sim +verilator+error+limit+100 || true)
echo "$output"

if grep -qx "Result: PASSED" <<< "$output"; then
    exit 0
fi
exit 1

// File: testbench/fmc_ft245_rx_bridge_properties.sv
`default_nettype none

module fmc_ft245_rx_bridge_properties (
    input  wire logic                  fmc_clk,
    input  wire logic                  reset,
    input  wire ft245_pkg::vadj_code_t set_vadj,
    input  wire logic                  vadj_en,
    input  wire logic                  fmc_oen,
    input  wire logic                  fmc_rdn,
    input  wire logic                  out_valid,
    input  wire ft245_pkg::ft_beat_t   out_beat,
    input  wire logic                  out_ready
);

    timeunit 1ns;
    timeprecision 100ps;

    // sticky, read by the testbench top
    logic violation = 1'b0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // power sequencing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    power_code: assert property (@(posedge fmc_clk) disable iff (reset)
        vadj_en |-> set_vadj == ft245_pkg::VADJ_2V5)
    else
    begin
        violation = 1'b1;
        $error("vadj_en high before set_vadj selected 2.5 V");
    end

    // rise seen on the fourth sample, i.e. set on the third edge out of reset
    power_ramp: assert property (@(posedge fmc_clk) disable iff (reset)
        $rose(vadj_en) |-> !$past(reset, 3) && $past(reset, 4))
    else
    begin
        violation = 1'b1;
        $error("vadj_en did not rise exactly three edges after reset");
    end

    power_hold: assert property (@(posedge fmc_clk) disable iff (reset)
        vadj_en |=> vadj_en)
    else
    begin
        violation = 1'b1;
        $error("vadj_en dropped without a reset");
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus strobes and stream
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    no_early_read: assert property (@(posedge fmc_clk) disable iff (reset)
        !vadj_en |-> fmc_oen && fmc_rdn)
    else
    begin
        violation = 1'b1;
        $error("bus strobe active while the rail is off");
    end

    rdn_after_oen: assert property (@(posedge fmc_clk) disable iff (reset)
        !fmc_rdn |-> $past(!fmc_oen))
    else
    begin
        violation = 1'b1;
        $error("fmc_rdn low without fmc_oen low on the edge before");
    end

    oen_after_rdn: assert property (@(posedge fmc_clk) disable iff (reset)
        $rose(fmc_oen) |-> fmc_rdn && $past(fmc_rdn))
    else
    begin
        violation = 1'b1;
        $error("fmc_oen released before fmc_rdn");
    end

    stream_hold: assert property (@(posedge fmc_clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_beat))
    else
    begin
        violation = 1'b1;
        $error("stream beat changed while stalled");
    end

endmodule

`default_nettype wire

// File: testbench/fmc_ft245_rx_bridge_tb.sv
`default_nettype none

module fmc_ft245_rx_bridge_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          WORD_COUNT     = 200;
    localparam int          TIMEOUT_CYCLES = WORD_COUNT * 20 + 200;
    localparam logic [15:0] LFSR_SEED      = 16'd47949;
    localparam logic [15:0] LFSR_TAPS      = 16'hB400;

    logic                  fmc_clk;
    logic                  reset;
    logic                  fmc_rxfn;
    ft245_pkg::ft_data_t   fmc_data;
    ft245_pkg::ft_be_t     fmc_be;
    logic                  fmc_oen;
    logic                  fmc_rdn;
    ft245_pkg::vadj_code_t set_vadj;
    logic                  vadj_en;
    logic                  out_valid;
    ft245_pkg::ft_beat_t   out_beat;
    logic                  out_ready;
    logic                  property_failed;

    // chip model and scoreboard
    ft245_pkg::ft_beat_t words [WORD_COUNT];
    ft245_pkg::ft_beat_t expected_q [$];
    logic [15:0]         lfsr_state;
    int                  word_idx;
    int                  beats_rcvd;
    int                  cycle_count;
    int                  gap_left;
    int                  ready_left;
    int                  words_after_af;

    // dut outputs as they stood through the last rising edge
    logic                rdn_seen;
    logic                af_seen;
    logic                valid_seen;
    ft245_pkg::ft_beat_t beat_seen;

    tb_clock_gen i_tb_clock_gen (
        .fmc_clk (fmc_clk),
        .reset   (reset)
    );

    fmc_ft245_rx_bridge i_fmc_ft245_rx_bridge (
        .fmc_clk   (fmc_clk),
        .reset     (reset),
        .fmc_rxfn  (fmc_rxfn),
        .fmc_data  (fmc_data),
        .fmc_be    (fmc_be),
        .fmc_oen   (fmc_oen),
        .fmc_rdn   (fmc_rdn),
        .set_vadj  (set_vadj),
        .vadj_en   (vadj_en),
        .out_valid (out_valid),
        .out_beat  (out_beat),
        .out_ready (out_ready)
    );

    bind fmc_ft245_rx_bridge fmc_ft245_rx_bridge_properties i_fmc_ft245_rx_bridge_properties (
        .fmc_clk   (fmc_clk),
        .reset     (reset),
        .set_vadj  (set_vadj),
        .vadj_en   (vadj_en),
        .fmc_oen   (fmc_oen),
        .fmc_rdn   (fmc_rdn),
        .out_valid (out_valid),
        .out_beat  (out_beat),
        .out_ready (out_ready)
    );

    assign property_failed =
        i_fmc_ft245_rx_bridge.i_fmc_ft245_rx_bridge_properties.violation;

    // galois lfsr, one step per bit taken
    function automatic int next_bits(input int count);
        int value;
        value = 0;
        for (int i = 0; i < count; i++)
        begin
            value = (value << 1) | int'(lfsr_state[0]);
            if (lfsr_state[0])
                lfsr_state = (lfsr_state >> 1) ^ LFSR_TAPS;
            else
                lfsr_state = lfsr_state >> 1;
        end
        return value;
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    // chip moves to its next word after every accepting edge
    task automatic observe_bus();
        if (!rdn_seen && !fmc_rxfn)
        begin
            expected_q.push_back(words[word_idx]);
            word_idx++;
            if (af_seen)
                words_after_af++;
        end
    endtask

    task automatic check_stream_beat();
        ft245_pkg::ft_beat_t expected;
        if (valid_seen && out_ready)
        begin
            if (expected_q.size() == 0)
                stop_with_failure($sformatf("FAIL %0t: stream beat %0d has no bus word behind it",
                    $time, beats_rcvd));
            expected = expected_q.pop_front();
            assert (beat_seen == expected)
            else
                stop_with_failure($sformatf(
                    "FAIL %0t: beat %0d is data %h keep %b, expected data %h keep %b",
                    $time, beats_rcvd, beat_seen.data, beat_seen.keep,
                    expected.data, expected.keep));
            beats_rcvd++;
        end
    endtask

    task automatic drive_bus();
        if (fmc_oen)
            words_after_af = 0;
        if (gap_left > 0)
            gap_left--;
        else if (next_bits(3) == 0)
            gap_left = 1 + next_bits(2);
        // a real chip stops short of the margin once almost-full is up
        fmc_rxfn = (word_idx >= WORD_COUNT) || (gap_left > 0)
            || (words_after_af >= ft245_pkg::FIFO_MARGIN - 1);
        if (!fmc_oen && word_idx < WORD_COUNT)
        begin
            fmc_data = words[word_idx].data;
            fmc_be   = words[word_idx].keep;
        end
        else
        begin
            fmc_data = '0;
            fmc_be   = '0;
        end
    endtask

    task automatic drive_ready();
        if (ready_left > 0)
            ready_left--;
        else
        begin
            out_ready = (next_bits(1) == 1);
            // low stretches long enough to fill the fifo
            if (out_ready)
                ready_left = next_bits(4);
            else
                ready_left = 4 * (1 + next_bits(4)) - 1;
        end
    endtask

    initial
    begin
        lfsr_state     = LFSR_SEED;
        fmc_rxfn       = 1'b1;
        fmc_data       = '0;
        fmc_be         = '0;
        out_ready      = 1'b0;
        word_idx       = 0;
        beats_rcvd     = 0;
        cycle_count    = 0;
        gap_left       = 0;
        ready_left     = 0;
        words_after_af = 0;
        rdn_seen       = 1'b1;
        af_seen        = 1'b0;
        valid_seen     = 1'b0;
        beat_seen      = '0;
        for (int i = 0; i < WORD_COUNT; i++)
        begin
            words[i].data = ft245_pkg::ft_data_t'(next_bits(16));
            words[i].keep = ft245_pkg::ft_be_t'(next_bits(2));
        end
        while (beats_rcvd < WORD_COUNT)
        begin
            @(negedge fmc_clk);
            if (!reset)
            begin
                cycle_count++;
                if (property_failed)
                    stop_with_failure("a bound protocol assertion failed");
                if (cycle_count >= TIMEOUT_CYCLES)
                    stop_with_failure($sformatf("timeout after %0d cycles, %0d of %0d beats received",
                        cycle_count, beats_rcvd, WORD_COUNT));
                observe_bus();
                check_stream_beat();
                drive_bus();
                drive_ready();
            end
            rdn_seen   = fmc_rdn;
            af_seen    = i_fmc_ft245_rx_bridge.almost_full;
            valid_seen = out_valid;
            beat_seen  = out_beat;
        end
        if (expected_q.size() == 0 && !property_failed)
        begin
            $display("Result: PASSED");
            $finish;
        end
        else
            stop_with_failure("bus words left over or an assertion failed at the end of the run");
    end

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic fmc_clk,
    output logic reset
);

    timeunit 1ns;
    timeprecision 100ps;

    // 8 ns period
    initial
    begin
        fmc_clk = 1'b0;
        forever #4 fmc_clk = ~fmc_clk;
    end

    // held for 8 rising edges and released on the falling edge after them
    initial
    begin
        reset = 1'b1;
        repeat (8) @(posedge fmc_clk);
        @(negedge fmc_clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

// File: verilog/fmc_ft245_rx_bridge.sv
`default_nettype none

module fmc_ft245_rx_bridge (
    input  wire logic                fmc_clk,
    input  wire logic                reset,

    // ft245 receive pins
    input  wire logic                fmc_rxfn,
    input  wire ft245_pkg::ft_data_t fmc_data,
    input  wire ft245_pkg::ft_be_t   fmc_be,
    output logic                     fmc_oen,
    output logic                     fmc_rdn,

    // fmc voltage control
    output ft245_pkg::vadj_code_t    set_vadj,
    output logic                     vadj_en,

    // stream out
    output logic                     out_valid,
    output ft245_pkg::ft_beat_t      out_beat,
    input  wire logic                out_ready
);

    logic                capture_valid;
    ft245_pkg::ft_beat_t capture_beat;
    logic                almost_full;

    vadj_sequencer i_vadj_sequencer (
        .fmc_clk  (fmc_clk),
        .reset    (reset),
        .set_vadj (set_vadj),
        .vadj_en  (vadj_en)
    );

    // bus reads start only once the rail is up
    ft245_rx_engine i_ft245_rx_engine (
        .fmc_clk       (fmc_clk),
        .reset         (reset),
        .power_good    (vadj_en),
        .fmc_rxfn      (fmc_rxfn),
        .fmc_data      (fmc_data),
        .fmc_be        (fmc_be),
        .fmc_oen       (fmc_oen),
        .fmc_rdn       (fmc_rdn),
        .almost_full   (almost_full),
        .capture_valid (capture_valid),
        .capture_beat  (capture_beat)
    );

    rx_word_fifo i_rx_word_fifo (
        .fmc_clk     (fmc_clk),
        .reset       (reset),
        .push_valid  (capture_valid),
        .push_beat   (capture_beat),
        .almost_full (almost_full),
        .out_valid   (out_valid),
        .out_beat    (out_beat),
        .out_ready   (out_ready)
    );

endmodule

`default_nettype wire

// File: verilog/vadj_sequencer.sv
`default_nettype none

module vadj_sequencer (
    input  wire logic             fmc_clk,
    input  wire logic             reset,
    output ft245_pkg::vadj_code_t set_vadj,
    output logic                  vadj_en
);

    typedef enum logic [1:0] {
        SEQ_DISABLE,
        SEQ_SELECT,
        SEQ_ENABLE,
        SEQ_DONE
    } seq_state_t;

    seq_state_t state;

    // rail goes off first, code changes only while the rail is off
    always_ff @(posedge fmc_clk)
    begin
        if (reset)
        begin
            state    <= SEQ_DISABLE;
            set_vadj <= '0;
            vadj_en  <= 1'b0;
        end
        else
        begin
            case (state)
                SEQ_DISABLE:
                begin
                    vadj_en <= 1'b0;
                    state   <= SEQ_SELECT;
                end
                SEQ_SELECT:
                begin
                    set_vadj <= ft245_pkg::VADJ_2V5;
                    state    <= SEQ_ENABLE;
                end
                SEQ_ENABLE:
                begin
                    vadj_en <= 1'b1;
                    state   <= SEQ_DONE;
                end
                // rail stays up until the next reset
                default:
                    state <= SEQ_DONE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: vlog.f
common/ft245_pkg.sv
verilog/vadj_sequencer.sv
ft245/ft245_rx_engine.sv
ft245/rx_word_fifo.sv
verilog/fmc_ft245_rx_bridge.sv
testbench/tb_clock_gen.sv
testbench/fmc_ft245_rx_bridge_properties.sv
testbench/fmc_ft245_rx_bridge_tb.sv
